// File: fp_rename.f
+incdir+test
logic/fp_rename_pkg.sv
logic/fp_free_list.sv
logic/fp_rename_table.sv
logic/fp_rename_stage.sv
test/tb_fp_rename_stage.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_fp_rename_stage
FLIST     := fp_rename.f
PASS      := Done: no errors

SRCS    := $(shell grep -v '^+' $(FLIST))
HEADERS := test/tb_fp_rename_vectors.svh
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

// File: test/tb_fp_rename_vectors.svh
// Row: request, wb0, wb1, commit0, commit1, rc, ckpt, recover, delete, slot,
//      expected answer (src1 rdy src2 rdy src3 rdy old new ckpt), out_of_ckpt, empty
task automatic load_vectors();
    int prev;
    int nxt;
    add_vec(req_row(1, 2, 3, 1, 1, 1, 0, 0), NO_WB, NO_WB, NO_CM, NO_CM, 0, 0, 0, 0, 0,
            expect_rsp(1, 1, 2, 1, 3, 1, 0, 0, 0), 0, 0);        // Identity after reset
    add_vec(req_row(1, 2, 3, 1, 1, 1, 1, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 0, 0, 0, 0,
            expect_rsp(1, 1, 2, 1, 3, 1, 1, 32, 0), 0, 0);
    add_vec(req_row(1, 2, 0, 1, 1, 0, 2, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 0, 0, 0, 0,
            expect_rsp(32, 0, 2, 1, 0, 1, 2, 33, 0), 0, 0);
    add_vec(req_row(1, 2, 2, 1, 0, 1, 0, 0), wb_port(1, 32), NO_WB, NO_CM, NO_CM,
            0, 0, 0, 0, 0, expect_rsp(32, 1, 33, 1, 33, 0, 0, 0, 0), 0, 0);   // Bypass
    add_vec(req_row(1, 2, 3, 1, 1, 1, 0, 0), NO_WB, wb_port(2, 5), NO_CM, NO_CM,
            0, 0, 0, 0, 0, expect_rsp(32, 1, 33, 0, 3, 1, 0, 0, 0), 0, 0);    // Stale wb
    add_vec(req_row(2, 0, 0, 1, 0, 0, 3, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 1, 0, 0, 0,
            expect_rsp(33, 0, 0, 1, 0, 1, 3, 34, 1), 0, 0);      // Checkpoint into slot 1
    add_vec(req_row(3, 0, 0, 1, 0, 0, 0, 0), NO_WB, NO_WB, NO_CM, NO_CM, 0, 1, 0, 0, 0,
            expect_rsp(34, 0, 0, 1, 0, 1, 0, 0, 2), 0, 0);
    add_vec(req_row(1, 0, 0, 1, 0, 0, 1, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 0, 0, 0, 0,
            expect_rsp(32, 1, 0, 1, 0, 1, 32, 35, 2), 0, 0);
    add_vec(req_row(3, 0, 0, 1, 0, 0, 3, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 0, 0, 0, 0,
            expect_rsp(34, 0, 0, 1, 0, 1, 34, 36, 2), 0, 0);
    add_vec(req_row(1, 0, 0, 1, 0, 0, 5, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 0, 1, 0, 1,
            expect_rsp(0, 0, 0, 0, 0, 0, 0, 0, 1), 0, 0);        // Branch recovery
    add_vec(req_row(1, 3, 2, 1, 1, 1, 0, 0), wb_port(3, 34), NO_WB, NO_CM, NO_CM,
            0, 0, 0, 0, 0, expect_rsp(32, 1, 34, 1, 33, 0, 0, 0, 1), 0, 0);
    add_vec(req_row(4, 0, 2, 1, 0, 1, 4, 1), NO_WB, wb_port(2, 33), NO_CM, NO_CM,
            0, 0, 0, 0, 0, expect_rsp(4, 1, 0, 1, 33, 1, 4, 35, 1), 0, 0);    // Head rolled back
    add_vec(req_row(1, 0, 0, 1, 0, 0, 0, 0), NO_WB, NO_WB, commit_port(1, 32, 1),
            commit_port(2, 33, 2), 0, 0, 0, 0, 0,
            expect_rsp(32, 1, 0, 1, 0, 1, 0, 0, 1), 0, 0);
    add_vec(req_row(1, 0, 0, 1, 0, 0, 6, 1), NO_WB, NO_WB, NO_CM, NO_CM, 1, 0, 0, 0, 0,
            expect_rsp(0, 0, 0, 0, 0, 0, 0, 0, 0), 0, 0);        // Exception recovery
    add_vec(req_row(1, 2, 3, 1, 1, 1, 0, 0), NO_WB, NO_WB, NO_CM, NO_CM, 0, 0, 0, 0, 0,
            expect_rsp(32, 1, 33, 1, 3, 1, 0, 0, 0), 0, 0);
    add_vec(req_row(0, 0, 0, 0, 0, 0, 5, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 1, 0, 0, 0,
            expect_rsp(0, 1, 0, 1, 0, 1, 5, 34, 1), 0, 0);
    add_vec(req_row(0, 0, 0, 0, 0, 0, 6, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 1, 0, 0, 0,
            expect_rsp(0, 1, 0, 1, 0, 1, 6, 35, 2), 0, 0);
    add_vec(req_row(0, 0, 0, 0, 0, 0, 7, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 1, 0, 0, 0,
            expect_rsp(0, 1, 0, 1, 0, 1, 7, 36, 3), 1, 0);       // Three live checkpoints
    add_vec(req_row(0, 0, 0, 0, 0, 0, 8, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 0, 0, 1, 0,
            expect_rsp(0, 1, 0, 1, 0, 1, 8, 37, 3), 0, 0);
    prev = 9;
    for (int k = 0; k < 28; k++) begin                           // Drain the free list
        nxt = (k < 26) ? 38 + k : k - 25;                        // Freed 1 and 2 come last
        add_vec(req_row(0, 0, 0, 0, 0, 0, 9, 1), NO_WB, NO_WB, NO_CM, NO_CM, 0, 0, 0, 0, 0,
                expect_rsp(0, 1, 0, 1, 0, 1, prev, nxt, 3), 0, (k == 27) ? 1 : 0);
        prev = nxt;
    end
    add_vec(req_row(9, 9, 9, 0, 1, 0, 0, 0), NO_WB, NO_WB, NO_CM, NO_CM, 0, 0, 0, 0, 0,
            expect_rsp(2, 1, 2, 0, 2, 1, 0, 0, 3), 0, 1);
endtask

// File: test/tb_fp_rename_stage.sv
`timescale 1ns/100ps

module tb_fp_rename_stage import fp_rename_pkg::*; ();

    localparam int NUM_WB       = 2;
    localparam int NUM_COMMIT   = 2;
    localparam int RESET_CYCLES = 10;

    // One cycle of stimulus plus what the DUT must answer for it
    typedef struct packed {
        rename_req_t req;
        wb_t         wb0;
        wb_t         wb1;
        commit_t     c0;
        commit_t     c1;
        logic        rc;                // Exception recovery
        logic        ckp;               // Take a checkpoint
        logic        rec;               // Branch recovery
        logic        del;               // Drop oldest checkpoint
        ckpt_ptr_t   slot;              // Branch recovery slot
        rename_rsp_t rsp;
        logic        ooc;               // Expected out of checkpoints
        logic        empty;             // Expected free list empty
    } vec_t;

    localparam wb_t     NO_WB = '0;
    localparam commit_t NO_CM = '0;

    logic                     clk_i;
    logic                     rstn_i;
    rename_req_t              req;
    wb_t [NUM_WB-1:0]         wb;
    commit_t [NUM_COMMIT-1:0] cm;
    logic                     recover_commit;
    logic                     do_checkpoint;
    logic                     do_recover;
    logic                     delete_checkpoint;
    ckpt_ptr_t                recover_ckpt;
    rename_rsp_t              rsp;
    logic                     out_of_checkpoints;
    logic                     free_empty;

    vec_t vecs[$];
    int   rsp_errs;
    int   flag_errs;
    int   cycle_cnt;

    fp_rename_stage #(
        .NUM_WB     (NUM_WB),
        .NUM_COMMIT (NUM_COMMIT)
    ) u_dut (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req),
        .wb_i                 (wb),
        .commit_i             (cm),
        .recover_commit_i     (recover_commit),
        .do_checkpoint_i      (do_checkpoint),
        .do_recover_i         (do_recover),
        .delete_checkpoint_i  (delete_checkpoint),
        .recover_ckpt_i       (recover_ckpt),
        .rsp_o                (rsp),
        .out_of_checkpoints_o (out_of_checkpoints),
        .free_empty_o         (free_empty)
    );

    function automatic rename_req_t req_row(input int s1, s2, s3, u1, u2, u3, d, w);
        rename_req_t r;
        r.src1      = areg_t'(s1);
        r.src2      = areg_t'(s2);
        r.src3      = areg_t'(s3);
        r.use_src1  = u1[0];
        r.use_src2  = u2[0];
        r.use_src3  = u3[0];
        r.dst       = areg_t'(d);
        r.write_dst = w[0];
        return r;
    endfunction

    function automatic rename_rsp_t expect_rsp(input int p1, r1, p2, r2, p3, r3, od, nd, ck);
        rename_rsp_t r;
        r.src1    = preg_t'(p1);
        r.rdy1    = r1[0];
        r.src2    = preg_t'(p2);
        r.rdy2    = r2[0];
        r.src3    = preg_t'(p3);
        r.rdy3    = r3[0];
        r.old_dst = preg_t'(od);
        r.new_dst = preg_t'(nd);
        r.ckpt    = ckpt_ptr_t'(ck);
        return r;
    endfunction

    function automatic wb_t wb_port(input int a, p);
        wb_t w;
        w.valid = 1'b1;
        w.areg  = areg_t'(a);
        w.preg  = preg_t'(p);
        return w;
    endfunction

    function automatic commit_t commit_port(input int a, np, op);
        commit_t c;
        c.valid    = 1'b1;
        c.areg     = areg_t'(a);
        c.new_preg = preg_t'(np);
        c.old_preg = preg_t'(op);
        return c;
    endfunction

    task automatic add_vec(input rename_req_t r, input wb_t w0, w1, input commit_t c0, c1,
                           input int rc, ckp, rec, del, slot, input rename_rsp_t exp,
                           input int ooc, empty);
        vec_t v;
        v = '{r, w0, w1, c0, c1, rc[0], ckp[0], rec[0], del[0], ckpt_ptr_t'(slot),
              exp, ooc[0], empty[0]};
        vecs.push_back(v);
    endtask

    `include "tb_fp_rename_vectors.svh"

    task automatic drive_vec(input vec_t v);
        req               = v.req;
        wb[0]             = v.wb0;
        wb[1]             = v.wb1;
        cm[0]             = v.c0;
        cm[1]             = v.c1;
        recover_commit    = v.rc;
        do_checkpoint     = v.ckp;
        do_recover        = v.rec;
        delete_checkpoint = v.del;
        recover_ckpt      = v.slot;
    endtask

    task automatic check_rsp(input int row, input rename_rsp_t got, input rename_rsp_t exp);
        if (got !== exp) begin
            rsp_errs++;
            $display("FAIL %0t: row %0d rename answer %h, expected %h", $time, row, got, exp);
        end
    endtask

    task automatic check_flag(input int row, input string name, input logic got, exp);
        if (got !== exp) begin
            flag_errs++;
            $display("FAIL %0t: row %0d %s is %b, expected %b", $time, row, name, got, exp);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;             // 100 ns period
    end

    // Watchdog sized from the table, loaded before the first edge
    initial begin
        cycle_cnt = 0;
        do begin
            @(posedge clk_i);
            cycle_cnt++;
        end while (cycle_cnt < RESET_CYCLES + vecs.size() + 20);
        $display("Run timed out after %0d cycles", cycle_cnt);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        vec_t idle;
        idle      = '0;
        rsp_errs  = 0;
        flag_errs = 0;
        rstn_i    = 1'b0;
        drive_vec(idle);                        // All inputs quiet during reset
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        drive_vec(vecs[0]);
        for (int i = 0; i < vecs.size(); i++) begin
            @(negedge clk_i);                   // Answer of row i is settled here
            check_rsp(i, rsp, vecs[i].rsp);
            check_flag(i, "out_of_checkpoints", out_of_checkpoints, vecs[i].ooc);
            check_flag(i, "free_empty", free_empty, vecs[i].empty);
            if (i + 1 < vecs.size()) drive_vec(vecs[i+1]);
            else drive_vec(idle);
        end
        $display("Errors: %0d answer, %0d flag", rsp_errs, flag_errs);
        if (rsp_errs + flag_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: logic/fp_rename_stage.sv
`timescale 1ns/100ps

module fp_rename_stage import fp_rename_pkg::*; #(
    parameter int NUM_WB     = 2,                           // FP writeback ports
    parameter int NUM_COMMIT = 2                            // Commit ports
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  rename_req_t              req_i,
    input  wb_t [NUM_WB-1:0]         wb_i,
    input  commit_t [NUM_COMMIT-1:0] commit_i,
    input  logic                     recover_commit_i,
    input  logic                     do_checkpoint_i,
    input  logic                     do_recover_i,
    input  logic                     delete_checkpoint_i,
    input  ckpt_ptr_t                recover_ckpt_i,
    output rename_rsp_t              rsp_o,
    output logic                     out_of_checkpoints_o,  // No checkpoint may be asked
    output logic                     free_empty_o           // No destination may be renamed
);

    preg_t      free_reg;                                   // Free list head, used as new dst
    logic       alloc;                                      // Table consumed the head
    ckpt_save_t ckpt_save;

    // Free list follows the table's allocation and checkpoint decisions
    fp_free_list #(
        .NUM_COMMIT (NUM_COMMIT)
    ) u_free_list (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .alloc_i          (alloc),
        .ckpt_save_i      (ckpt_save),
        .do_recover_i     (do_recover_i),
        .recover_ckpt_i   (recover_ckpt_i),
        .recover_commit_i (recover_commit_i),
        .commit_i         (commit_i),
        .free_reg_o       (free_reg),
        .empty_o          (free_empty_o)
    );

    fp_rename_table #(
        .NUM_WB     (NUM_WB),
        .NUM_COMMIT (NUM_COMMIT)
    ) u_rename_table (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req_i),
        .new_dst_i            (free_reg),
        .wb_i                 (wb_i),
        .commit_i             (commit_i),
        .recover_commit_i     (recover_commit_i),
        .do_checkpoint_i      (do_checkpoint_i),
        .do_recover_i         (do_recover_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .recover_ckpt_i       (recover_ckpt_i),
        .rsp_o                (rsp_o),
        .alloc_o              (alloc),
        .ckpt_save_o          (ckpt_save),
        .out_of_checkpoints_o (out_of_checkpoints_o)
    );

endmodule

// File: logic/fp_rename_table.sv
`timescale 1ns/100ps

module fp_rename_table import fp_rename_pkg::*; #(
    parameter int NUM_WB     = 2,
    parameter int NUM_COMMIT = 2
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  rename_req_t              req_i,
    input  preg_t                    new_dst_i,             // Head of the free list
    input  wb_t [NUM_WB-1:0]         wb_i,
    input  commit_t [NUM_COMMIT-1:0] commit_i,
    input  logic                     recover_commit_i,      // Restore commit map
    input  logic                     do_checkpoint_i,       // Open a new version after rename
    input  logic                     do_recover_i,          // Go back to a saved version
    input  logic                     delete_checkpoint_i,   // Oldest checkpoint resolved
    input  ckpt_ptr_t                recover_ckpt_i,
    output rename_rsp_t              rsp_o,
    output logic                     alloc_o,               // Pop strobe to the free list
    output ckpt_save_t               ckpt_save_o,
    output logic                     out_of_checkpoints_o
);

    localparam int CNT_W = $clog2(NUM_CHECKPOINTS) + 1;

    preg_t                   map_q [NUM_CHECKPOINTS][NUM_ISA_REGS];
    logic [NUM_ISA_REGS-1:0] rdy_q [NUM_CHECKPOINTS];
    preg_t                   commit_map_q [NUM_ISA_REGS];

    ckpt_ptr_t  version_head_q;                             // Version in use
    ckpt_ptr_t  version_tail_q;                             // Oldest live version
    logic [CNT_W-1:0] num_ckpt_q;                           // Live checkpoints

    logic                    recover_any;
    logic                    ckpt_en;
    ckpt_ptr_t               head_nxt;                      // Slot a checkpoint fills
    ckpt_ptr_t               tail_nxt;
    logic [NUM_ISA_REGS-1:0] wb_set [NUM_CHECKPOINTS];      // Ready bits raised this cycle
    logic [NUM_COMMIT-1:0]   commit_en;

    assign recover_any = do_recover_i | recover_commit_i;
    assign ckpt_en     = do_checkpoint_i & ~out_of_checkpoints_o & ~recover_any;
    assign alloc_o     = req_i.write_dst & ~recover_any;
    assign head_nxt    = version_head_q + 1'b1;
    assign tail_nxt    = version_tail_q + ckpt_ptr_t'(delete_checkpoint_i);

    assign ckpt_save_o.valid = ckpt_en;
    assign ckpt_save_o.slot  = head_nxt;

    assign out_of_checkpoints_o = (num_ckpt_q == CNT_W'(NUM_CHECKPOINTS - 1));

    // A writeback only counts where the mapping still holds that register
    always_comb begin
        for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
            wb_set[v] = '0;
            for (int p = 0; p < NUM_WB; p++) begin
                if (wb_i[p].valid && (map_q[v][wb_i[p].areg] == wb_i[p].preg)) begin
                    wb_set[v][wb_i[p].areg] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_COMMIT; i++) begin
            commit_en[i] = commit_i[i].valid & ~recover_commit_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                for (int a = 0; a < NUM_ISA_REGS; a++) begin
                    map_q[v][a] <= preg_t'(a);              // Identity map
                end
                rdy_q[v] <= '1;
            end
            for (int a = 0; a < NUM_ISA_REGS; a++) begin
                commit_map_q[a] <= preg_t'(a);
            end
            version_head_q <= '0;
            version_tail_q <= '0;
            num_ckpt_q     <= '0;
            rsp_o          <= '0;
        end else begin
            for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                rdy_q[v] <= rdy_q[v] | wb_set[v];
            end

            // Ascending loop so the later port wins on the same register
            for (int i = 0; i < NUM_COMMIT; i++) begin
                if (commit_en[i]) commit_map_q[commit_i[i].areg] <= commit_i[i].new_preg;
            end

            if (recover_commit_i) begin
                // Exception: committed state becomes version 0, all values exist
                for (int a = 0; a < NUM_ISA_REGS; a++) begin
                    map_q[0][a] <= commit_map_q[a];
                end
                rdy_q[0]       <= '1;
                version_head_q <= '0;
                version_tail_q <= '0;
                num_ckpt_q     <= '0;
                rsp_o          <= '0;
            end else if (do_recover_i) begin
                version_head_q <= recover_ckpt_i;
                version_tail_q <= tail_nxt;
                num_ckpt_q     <= CNT_W'(ckpt_ptr_t'(recover_ckpt_i - tail_nxt)); // Mod 4
                rsp_o          <= '0;                       // Request dropped
                rsp_o.ckpt     <= recover_ckpt_i;
            end else begin
                version_tail_q <= tail_nxt;
                version_head_q <= version_head_q + ckpt_ptr_t'(ckpt_en);
                num_ckpt_q     <= num_ckpt_q + CNT_W'(ckpt_en)
                                  - CNT_W'(delete_checkpoint_i);

                // Source reads see the old mapping, bypassing same-cycle writebacks
                rsp_o.src1 <= map_q[version_head_q][req_i.src1];
                rsp_o.rdy1 <= rdy_q[version_head_q][req_i.src1]
                              | wb_set[version_head_q][req_i.src1] | ~req_i.use_src1;
                rsp_o.src2 <= map_q[version_head_q][req_i.src2];
                rsp_o.rdy2 <= rdy_q[version_head_q][req_i.src2]
                              | wb_set[version_head_q][req_i.src2] | ~req_i.use_src2;
                rsp_o.src3 <= map_q[version_head_q][req_i.src3];
                rsp_o.rdy3 <= rdy_q[version_head_q][req_i.src3]
                              | wb_set[version_head_q][req_i.src3] | ~req_i.use_src3;
                rsp_o.old_dst <= map_q[version_head_q][req_i.dst];
                rsp_o.new_dst <= alloc_o ? new_dst_i : '0;
                rsp_o.ckpt    <= version_head_q + ckpt_ptr_t'(ckpt_en);

                // New version starts as a copy, writebacks included
                if (ckpt_en) begin
                    for (int a = 0; a < NUM_ISA_REGS; a++) begin
                        map_q[head_nxt][a] <= map_q[version_head_q][a];
                    end
                    rdy_q[head_nxt] <= rdy_q[version_head_q] | wb_set[version_head_q];
                end

                // Rename lands last so it overrides copy and writeback
                if (alloc_o) begin
                    map_q[version_head_q][req_i.dst] <= new_dst_i;
                    rdy_q[version_head_q][req_i.dst] <= 1'b0;
                    if (ckpt_en) begin
                        map_q[head_nxt][req_i.dst] <= new_dst_i;
                        rdy_q[head_nxt][req_i.dst] <= 1'b0;
                    end
                end
            end
        end
    end

    // Caller has to honour the status flag before asking for a version
    a_ckpt_limit: assert property (
        @(posedge clk_i) disable iff (!rstn_i) do_checkpoint_i |-> !out_of_checkpoints_o
    ) else $error("checkpoint requested with no free version");

    a_single_recovery: assert property (
        @(posedge clk_i) disable iff (!rstn_i) !(do_recover_i && recover_commit_i)
    ) else $error("branch and exception recovery in the same cycle");

endmodule

// File: logic/fp_free_list.sv
`timescale 1ns/100ps

module fp_free_list import fp_rename_pkg::*; #(
    parameter int NUM_COMMIT = 2
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         alloc_i,           // Pop the head this cycle
    input  ckpt_save_t                   ckpt_save_i,       // Save head into a slot
    input  logic                         do_recover_i,      // Branch recovery
    input  ckpt_ptr_t                    recover_ckpt_i,    // Slot to restore
    input  logic                         recover_commit_i,  // Exception recovery
    input  commit_t [NUM_COMMIT-1:0]     commit_i,
    output preg_t                        free_reg_o,        // Next free register
    output logic                         empty_o
);

    // Registers not in the reset map start in the ring
    localparam int FREE_SLOTS = NUM_PHYS_REGS - NUM_ISA_REGS;
    localparam int PTR_W      = $clog2(FREE_SLOTS) + 1;   // Extra wrap bit

    preg_t            ring_q [FREE_SLOTS];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W-1:0] commit_head_q;                        // Head as seen by committed code
    logic [PTR_W-1:0] saved_head_q [NUM_CHECKPOINTS];

    logic [NUM_COMMIT-1:0] push_en;
    logic [PTR_W-1:0]      push_ptr [NUM_COMMIT];
    logic [PTR_W-1:0]      push_cnt;
    logic [PTR_W-1:0]      head_alloc;                      // Head after this cycle's pop

    assign head_alloc = head_q + PTR_W'(alloc_i);
    assign free_reg_o = ring_q[head_q[PTR_W-2:0]];
    assign empty_o    = (head_q == tail_q);

    // Pack valid frees back to back at the tail
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < NUM_COMMIT; i++) begin
            push_en[i]  = commit_i[i].valid & ~recover_commit_i;
            push_ptr[i] = tail_q + push_cnt;
            if (push_en[i]) push_cnt = push_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < FREE_SLOTS; i++) begin
                ring_q[i] <= preg_t'(NUM_ISA_REGS + i);     // 32 to 63 free
            end
            for (int k = 0; k < NUM_CHECKPOINTS; k++) begin
                saved_head_q[k] <= '0;
            end
            head_q        <= '0;
            tail_q        <= PTR_W'(FREE_SLOTS);            // Ring full
            commit_head_q <= '0;
        end else begin
            // Head moves by recovery first, pop otherwise
            if (recover_commit_i) begin
                head_q <= commit_head_q;
            end else if (do_recover_i) begin
                head_q <= saved_head_q[recover_ckpt_i];
            end else begin
                head_q <= head_alloc;
            end

            // Snapshot includes the pop of the checkpointing rename
            if (ckpt_save_i.valid) saved_head_q[ckpt_save_i.slot] <= head_alloc;

            for (int i = 0; i < NUM_COMMIT; i++) begin
                if (push_en[i]) ring_q[push_ptr[i][PTR_W-2:0]] <= commit_i[i].old_preg;
            end
            tail_q        <= tail_q + push_cnt;
            commit_head_q <= commit_head_q + push_cnt;      // One per committed rename
        end
    end

    // The table must never rename into an exhausted list
    a_no_alloc_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i) alloc_i |-> !empty_o
    ) else $error("free list popped while empty");

endmodule

// File: logic/fp_rename_pkg.sv
package fp_rename_pkg;

    localparam int NUM_ISA_REGS    = 32;    // Architectural FP registers
    localparam int NUM_PHYS_REGS   = 64;    // Physical FP registers
    localparam int NUM_CHECKPOINTS = 4;     // Map versions kept for branch recovery

    typedef logic [$clog2(NUM_ISA_REGS)-1:0]    areg_t;     // Architectural index
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0]   preg_t;     // Physical index
    typedef logic [$clog2(NUM_CHECKPOINTS)-1:0] ckpt_ptr_t; // Checkpoint slot

    // Rename request of one instruction, sampled every edge
    typedef struct packed {
        areg_t src1;
        areg_t src2;
        areg_t src3;
        logic  use_src1;        // Source flags, clear means ready forced
        logic  use_src2;
        logic  use_src3;
        areg_t dst;
        logic  write_dst;       // Instruction writes an FP register
    } rename_req_t;

    // Registered rename answer
    typedef struct packed {
        preg_t     src1;
        logic      rdy1;
        preg_t     src2;
        logic      rdy2;
        preg_t     src3;
        logic      rdy3;
        preg_t     old_dst;     // Mapping replaced by this rename
        preg_t     new_dst;     // Register popped from the free list
        ckpt_ptr_t ckpt;        // Version head after the edge
    } rename_rsp_t;

    typedef struct packed {
        logic  valid;
        areg_t areg;
        preg_t preg;
    } wb_t;

    typedef struct packed {
        logic  valid;
        areg_t areg;
        preg_t new_preg;        // Goes into the commit map
        preg_t old_preg;        // Goes back to the free list
    } commit_t;

    typedef struct packed {
        logic      valid;
        ckpt_ptr_t slot;        // Version being filled
    } ckpt_save_t;

endpackage
